/* design/reconfig_bus_pkg.sv */
// widths are fixed for a single pma channel and the user request must stay stable until busy drops
package reconfig_bus_pkg;

   //////////////////////////////////////////////////////////////////////
   // port widths
   //////////////////////////////////////////////////////////////////////

   localparam int XR_DATA_W   = 32;   // user and pma data word
   localparam int XR_ADDR_W   = 11;   // absolute pma register address
   localparam int XR_OFFSET_W = 6;    // user feature select

   //////////////////////////////////////////////////////////////////////
   // user port
   //////////////////////////////////////////////////////////////////////

   // one request at a time, sampled on go and used until busy falls
   typedef struct packed {
      logic                   write;    // high for read-modify-write
      logic [XR_OFFSET_W-1:0] offset;   // analog feature offset
      logic [XR_DATA_W-1:0]   wdata;    // user value, lsb aligned
   } user_req_t;

   //////////////////////////////////////////////////////////////////////
   // control port
   //////////////////////////////////////////////////////////////////////

   // single op per go pulse
   typedef enum logic {
      CTRL_READ  = 1'b0,
      CTRL_WRITE = 1'b1
   } ctrl_op_t;

   // held steady from ctrl_go until the op completes
   typedef struct packed {
      ctrl_op_t             op;
      logic [XR_ADDR_W-1:0] addr;     // channel base already added
      logic [XR_DATA_W-1:0] wdata;    // whole merged word
   } ctrl_req_t;

   // op completes on the first low ctrl_wait seen
   // from the second cycle after go onwards
   // readdata is only valid in that completion cycle

endpackage

/* design/analog_map_pkg.sv */
// register map of one pma channel, indices are relative to the channel base and fields sit below bit 32
package analog_map_pkg;

   import reconfig_bus_pkg::*;

   //////////////////////////////////////////////////////////////////////
   // user feature offsets
   //////////////////////////////////////////////////////////////////////

   localparam logic [XR_OFFSET_W-1:0] OFS_VOD       = 6'd0;
   localparam logic [XR_OFFSET_W-1:0] OFS_POSTTAP1  = 6'd2;
   localparam logic [XR_OFFSET_W-1:0] OFS_RX_DCGAIN = 6'd16;
   localparam logic [XR_OFFSET_W-1:0] OFS_RX_EQCTRL = 6'd17;

   //////////////////////////////////////////////////////////////////////
   // pma register indices and field positions
   //////////////////////////////////////////////////////////////////////

   localparam logic [XR_ADDR_W-1:0] REG_VOD       = 11'h005;
   localparam logic [XR_ADDR_W-1:0] REG_TAPS      = 11'h003;   // shared by all tx taps
   localparam logic [XR_ADDR_W-1:0] REG_RX_EQ     = 11'h018;
   localparam logic [XR_ADDR_W-1:0] REG_RX_DCGAIN = 11'h019;

   localparam logic [4:0] FLD_VOD_OFS    = 5'd0;
   localparam logic [4:0] FLD_VOD_LEN    = 5'd6;
   localparam logic [4:0] FLD_TAP1_OFS   = 5'd3;
   localparam logic [4:0] FLD_TAP1_LEN   = 5'd5;
   localparam logic [4:0] FLD_DCGAIN_OFS = 5'd0;
   localparam logic [4:0] FLD_DCGAIN_LEN = 5'd4;
   localparam logic [4:0] FLD_EQ_OFS     = 5'd1;    // bit 0 belongs to something else
   localparam logic [4:0] FLD_EQ_LEN     = 5'd15;   // five 3-bit stages

   //////////////////////////////////////////////////////////////////////
   // field descriptor
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0] {
      KIND_PLAIN   = 2'd0,   // value goes straight into the field
      KIND_DCGAIN  = 2'd1,   // thermometer coded
      KIND_EQCTRL  = 2'd2,   // table lookup, read back from shadow
      KIND_ILLEGAL = 2'd3
   } field_kind_t;

   typedef struct packed {
      field_kind_t          kind;
      logic [XR_ADDR_W-1:0] addr;      // absolute register address
      logic [4:0]           bit_ofs;
      logic [4:0]           bit_len;
   } field_desc_t;

   //////////////////////////////////////////////////////////////////////
   // rx dc gain thermometer codes
   //////////////////////////////////////////////////////////////////////

   localparam int DCGAIN_LEVELS = 5;   // user codes 0..4

   // fills from the msb down
   localparam logic [3:0] DCGAIN_CODE [DCGAIN_LEVELS] = '{
      4'b0000, 4'b1000, 4'b1100, 4'b1110, 4'b1111
   };

   //////////////////////////////////////////////////////////////////////
   // rx equalizer settings
   //////////////////////////////////////////////////////////////////////

   // entry packs {eqv, eqd, eqc, eqb, eqa} so eqa lands on reg bits 3:1
   localparam logic [14:0] EQ_TABLE [16] = '{
      {3'b000, 3'b000, 3'b000, 3'b000, 3'b000},   // equalizer off
      {3'b000, 3'b000, 3'b000, 3'b000, 3'b011},   // low 0
      {3'b000, 3'b000, 3'b000, 3'b000, 3'b100},   // low 1
      {3'b100, 3'b000, 3'b000, 3'b000, 3'b111},   // low 2
      {3'b111, 3'b000, 3'b000, 3'b000, 3'b111},   // low 3
      {3'b000, 3'b000, 3'b000, 3'b111, 3'b111},   // low 4
      {3'b100, 3'b000, 3'b000, 3'b111, 3'b111},   // medium 0
      {3'b000, 3'b000, 3'b011, 3'b111, 3'b111},   // medium 1
      {3'b000, 3'b000, 3'b111, 3'b111, 3'b111},   // medium 2
      {3'b010, 3'b000, 3'b111, 3'b111, 3'b111},   // medium 3
      {3'b100, 3'b000, 3'b111, 3'b111, 3'b111},   // medium 4
      {3'b000, 3'b111, 3'b111, 3'b111, 3'b111},   // high 0
      {3'b010, 3'b111, 3'b111, 3'b111, 3'b111},   // high 1
      {3'b100, 3'b111, 3'b111, 3'b111, 3'b111},   // high 2
      {3'b110, 3'b111, 3'b111, 3'b111, 3'b111},   // high 3
      {3'b111, 3'b111, 3'b111, 3'b111, 3'b111}    // high 4
   };

endpackage

/* design/analog_field_decode.sv */
// purely combinational and the request must stay stable while busy is high since outputs follow it
`timescale 1ns/1ps

module analog_field_decode
   import reconfig_bus_pkg::*, analog_map_pkg::*;
#(
   parameter logic [XR_ADDR_W-1:0] PMA_BASE = 11'h000   // channel base address
)
(
   input  user_req_t              user_req,
   output field_desc_t            desc,
   output logic [XR_DATA_W-1:0]   field_value   // encoded and shifted into place
);

   logic [XR_DATA_W-1:0] enc_value;   // encoded, still lsb aligned
   logic [XR_DATA_W-1:0] len_mask;
   logic [2:0]           dcgain_idx;

   // codes above the top level saturate to all ones
   assign dcgain_idx = (user_req.wdata > (DCGAIN_LEVELS - 1)) ? 3'(DCGAIN_LEVELS - 1)
                                                               : user_req.wdata[2:0];

   //////////////////////////////////////////////////////////////////////
   // offset decode and value encode
   //////////////////////////////////////////////////////////////////////

   always_comb
   begin
      desc.kind    = KIND_ILLEGAL;
      desc.addr    = PMA_BASE;
      desc.bit_ofs = '0;
      desc.bit_len = '0;
      enc_value    = '0;
      case (user_req.offset)
         OFS_VOD:
         begin
            desc.kind    = KIND_PLAIN;
            desc.addr    = PMA_BASE + REG_VOD;
            desc.bit_ofs = FLD_VOD_OFS;
            desc.bit_len = FLD_VOD_LEN;
            enc_value    = user_req.wdata;
         end
         OFS_POSTTAP1:
         begin
            desc.kind    = KIND_PLAIN;
            desc.addr    = PMA_BASE + REG_TAPS;
            desc.bit_ofs = FLD_TAP1_OFS;
            desc.bit_len = FLD_TAP1_LEN;
            enc_value    = user_req.wdata;
         end
         OFS_RX_DCGAIN:
         begin
            desc.kind    = KIND_DCGAIN;
            desc.addr    = PMA_BASE + REG_RX_DCGAIN;
            desc.bit_ofs = FLD_DCGAIN_OFS;
            desc.bit_len = FLD_DCGAIN_LEN;
            enc_value    = {28'd0, DCGAIN_CODE[dcgain_idx]};   // thermometer
         end
         OFS_RX_EQCTRL:
         begin
            desc.kind    = KIND_EQCTRL;
            desc.addr    = PMA_BASE + REG_RX_EQ;
            desc.bit_ofs = FLD_EQ_OFS;
            desc.bit_len = FLD_EQ_LEN;
            enc_value    = {17'd0, EQ_TABLE[user_req.wdata[3:0]]};   // index in low nibble
         end
         default:
         begin
            // unlisted offset, sequencer flags it and does nothing
         end
      endcase
   end

   // trim to field length before shifting so neighbours stay clean
   assign len_mask    = (XR_DATA_W'(1) << desc.bit_len) - XR_DATA_W'(1);
   assign field_value = (enc_value & len_mask) << desc.bit_ofs;

   // map consistency, any legal field has to fit in the data word
   always_comb
   begin
      if (desc.kind != KIND_ILLEGAL)
         assert ((6'(desc.bit_ofs) + 6'(desc.bit_len)) <= 6'(XR_DATA_W))
         else $error("field at offset %0d len %0d runs past the word",
                     desc.bit_ofs, desc.bit_len);
   end

endmodule

/* design/rmw_sequencer.sv */
// one request in flight and ctrl_wait must rise the cycle after ctrl_go or the op completes early
`timescale 1ns/1ps

module rmw_sequencer
   import reconfig_bus_pkg::*, analog_map_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   // user side
   input  logic                 user_go,
   input  user_req_t            user_req,
   input  field_desc_t          desc,
   input  logic [XR_DATA_W-1:0] field_value,
   output logic                 user_busy,
   output logic                 offset_error,
   output logic                 channel_error,
   // control port
   input  logic                 ctrl_wait,
   input  logic [XR_DATA_W-1:0] ctrl_readdata,
   input  logic                 ctrl_illegal_ch,
   output logic                 ctrl_go,
   output ctrl_req_t            ctrl_req,
   // to readback
   output logic [XR_DATA_W-1:0] rd_word,
   output logic                 rd_capture,
   output logic                 eq_write
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_RD_ISSUE,   // ctrl_go for the read
      ST_RD_WAIT,
      ST_WR_ISSUE,   // ctrl_go for the merged write
      ST_WR_WAIT
   } state_t;

   state_t               state;
   logic                 wait_armed;   // past the first wait cycle
   logic                 in_wait;
   logic                 op_done;
   logic                 accept;
   logic [XR_DATA_W-1:0] fld_mask;
   logic [XR_DATA_W-1:0] merged;

   assign accept  = user_go && (state == ST_IDLE);   // go ignored while busy
   assign in_wait = (state == ST_RD_WAIT) || (state == ST_WR_WAIT);
   assign op_done = in_wait && wait_armed && !ctrl_wait;

   //////////////////////////////////////////////////////////////////////
   // read-modify-write merge
   //////////////////////////////////////////////////////////////////////

   assign fld_mask = ((XR_DATA_W'(1) << desc.bit_len) - XR_DATA_W'(1)) << desc.bit_ofs;
   assign merged   = (ctrl_readdata & ~fld_mask) | (field_value & fld_mask);

   //////////////////////////////////////////////////////////////////////
   // control FSM and error flags
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state         <= ST_IDLE;
         wait_armed    <= 1'b0;
         offset_error  <= 1'b0;
         channel_error <= 1'b0;
      end
      else
      begin
         channel_error <= ctrl_illegal_ch;        // straight pass, one cycle late
         wait_armed    <= in_wait && !op_done;    // low again on each new op
         case (state)
            ST_IDLE:
            begin
               if (accept)
               begin
                  offset_error <= (desc.kind == KIND_ILLEGAL);   // held until next go
                  if (desc.kind != KIND_ILLEGAL)
                     state <= ST_RD_ISSUE;
               end
            end
            ST_RD_ISSUE: state <= ST_RD_WAIT;
            ST_RD_WAIT:
            begin
               if (op_done)
                  state <= user_req.write ? ST_WR_ISSUE : ST_IDLE;
            end
            ST_WR_ISSUE: state <= ST_WR_WAIT;
            ST_WR_WAIT:
            begin
               if (op_done)
                  state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // control request payload
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         ctrl_req.op    <= CTRL_READ;   // every request starts with a read
         ctrl_req.addr  <= desc.addr;
         ctrl_req.wdata <= '0;
      end
      else if ((state == ST_RD_WAIT) && op_done && user_req.write)
      begin
         ctrl_req.op    <= CTRL_WRITE;
         ctrl_req.wdata <= merged;      // address stays from the read
      end
   end

   //////////////////////////////////////////////////////////////////////
   // outputs
   //////////////////////////////////////////////////////////////////////

   assign user_busy  = (state != ST_IDLE);
   assign ctrl_go    = (state == ST_RD_ISSUE) || (state == ST_WR_ISSUE);
   assign rd_word    = ctrl_readdata;   // only meaningful with rd_capture
   assign rd_capture = (state == ST_RD_WAIT) && op_done && !user_req.write;
   assign eq_write   = (state == ST_WR_WAIT) && op_done && (desc.kind == KIND_EQCTRL);

   // go pulses are single and the port answers with wait in the next cycle
   a_go_single: assert property (@(posedge clk) disable iff (reset)
      ctrl_go |=> (!ctrl_go && ctrl_wait))
      else $error("ctrl_go repeated or ctrl_wait did not rise after it");

   // control port must be idle before a new go
   a_go_no_wait: assert property (@(posedge clk) disable iff (reset)
      ctrl_go |-> !ctrl_wait)
      else $error("ctrl_go issued while ctrl_wait is high");

endmodule

/* design/field_readback.sv */
// rd_word is sampled only on rd_capture and the equalizer read returns the last index written
`timescale 1ns/1ps

module field_readback
   import reconfig_bus_pkg::*, analog_map_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  field_desc_t          desc,
   input  user_req_t            user_req,
   input  logic [XR_DATA_W-1:0] rd_word,
   input  logic                 rd_capture,
   input  logic                 eq_write,
   input  logic [XR_DATA_W-1:0] field_value,
   output logic [XR_DATA_W-1:0] user_readdata
);

   logic [3:0]           eq_shadow;    // last equalizer index written
   logic [XR_DATA_W-1:0] field_bits;   // field moved down to bit 0
   logic [2:0]           dcgain_lvl;
   logic [XR_DATA_W-1:0] rd_value;

   // extract
   assign field_bits = (rd_word >> desc.bit_ofs)
                     & ((XR_DATA_W'(1) << desc.bit_len) - XR_DATA_W'(1));

   // thermometer back to level, unknown patterns read as 0
   always_comb
   begin
      dcgain_lvl = 3'd0;
      for (int i = 0; i < DCGAIN_LEVELS; i++)
         if (field_bits[3:0] == DCGAIN_CODE[i])
            dcgain_lvl = 3'(i);
   end

   always_comb
   begin
      case (desc.kind)
         KIND_PLAIN:  rd_value = field_bits;
         KIND_DCGAIN: rd_value = {29'd0, dcgain_lvl};
         KIND_EQCTRL: rd_value = {28'd0, eq_shadow};   // table is not inverted
         default:     rd_value = '0;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // registers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         user_readdata <= '0;
         eq_shadow     <= 4'd0;
      end
      else
      begin
         if (rd_capture)
            user_readdata <= rd_value;   // lands as busy falls
         if (eq_write)
            eq_shadow <= user_req.wdata[3:0];
      end
   end

   // register must hold the new setting when the shadow moves
   a_eq_shadow_match: assert property (@(posedge clk) disable iff (reset)
      eq_write |-> (rd_word[15:1] == field_value[15:1]))
      else $error("equalizer register does not hold the written setting");

endmodule

/* design/analog_reconfig_top.sv */
// single pma channel at PMA_BASE and the user request must be held from go until busy falls
`timescale 1ns/1ps

module analog_reconfig_top
   import reconfig_bus_pkg::*, analog_map_pkg::*;
#(
   parameter logic [XR_ADDR_W-1:0] PMA_BASE = 11'h100   // channel base address
)
(
   input  logic                 clk,
   input  logic                 reset,
   // user port
   input  logic                 user_go,
   input  user_req_t            user_req,
   output logic                 user_busy,
   output logic                 offset_error,
   output logic                 channel_error,
   output logic [XR_DATA_W-1:0] user_readdata,
   // control port
   output logic                 ctrl_go,
   output ctrl_req_t            ctrl_req,
   input  logic                 ctrl_wait,
   input  logic                 ctrl_illegal_ch,
   input  logic [XR_DATA_W-1:0] ctrl_readdata
);

   field_desc_t          desc;          // decoded feature
   logic [XR_DATA_W-1:0] field_value;   // aligned write field
   logic [XR_DATA_W-1:0] rd_word;
   logic                 rd_capture;
   logic                 eq_write;

   //////////////////////////////////////////////////////////////////////
   // decode, sequence, readback
   //////////////////////////////////////////////////////////////////////

   analog_field_decode #(
      .PMA_BASE    (PMA_BASE)
   ) u_decode (
      .user_req    (user_req),
      .desc        (desc),
      .field_value (field_value)
   );

   rmw_sequencer u_seq (
      .clk             (clk),
      .reset           (reset),
      .user_go         (user_go),
      .user_req        (user_req),
      .desc            (desc),
      .field_value     (field_value),
      .user_busy       (user_busy),
      .offset_error    (offset_error),
      .channel_error   (channel_error),
      .ctrl_wait       (ctrl_wait),
      .ctrl_readdata   (ctrl_readdata),
      .ctrl_illegal_ch (ctrl_illegal_ch),
      .ctrl_go         (ctrl_go),
      .ctrl_req        (ctrl_req),
      .rd_word         (rd_word),
      .rd_capture      (rd_capture),
      .eq_write        (eq_write)
   );

   field_readback u_readback (
      .clk           (clk),
      .reset         (reset),
      .desc          (desc),
      .user_req      (user_req),
      .rd_word       (rd_word),
      .rd_capture    (rd_capture),
      .eq_write      (eq_write),
      .field_value   (field_value),
      .user_readdata (user_readdata)
   );

endmodule

/* bench/pma_reg_model.sv */
// behavioral pma register array with one op at a time and no check of the address range
`timescale 1ns/1ps

module pma_reg_model
   import reconfig_bus_pkg::*;
#(
   parameter logic [31:0] SEED = 32'h3ace178f   // wait length sequence
)
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 ctrl_go,
   input  ctrl_req_t            ctrl_req,
   output logic                 ctrl_wait,
   output logic [XR_DATA_W-1:0] ctrl_readdata,
   output logic                 ctrl_illegal_ch,
   // bench side
   input  logic                 bad_channel,   // flag the next op as illegal channel
   input  logic                 preload_en,
   input  logic [XR_ADDR_W-1:0] preload_addr,
   input  logic [XR_DATA_W-1:0] preload_data
);

   logic [XR_DATA_W-1:0] regs [2**XR_ADDR_W];
   ctrl_req_t            held;        // op in progress
   int                   wait_left;
   int                   seed;

   // power-up contents, every address bit shows up in the word
   function automatic logic [31:0] fill_word(input logic [10:0] a);
      return {a, a, a[9:0]} ^ 32'h5a5a_c3c3;
   endfunction

   always @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         seed = SEED;
         for (int a = 0; a < 2**XR_ADDR_W; a++)
            regs[a] <= fill_word(11'(a));
         held            <= '0;
         ctrl_wait       <= 1'b0;
         ctrl_illegal_ch <= 1'b0;
         wait_left       <= 0;
      end
      else
      begin
         if (preload_en)
            regs[preload_addr] <= preload_data;   // backdoor load
         if (ctrl_go)
         begin
            held            <= ctrl_req;
            ctrl_illegal_ch <= bad_channel;
            if (ctrl_req.op == CTRL_WRITE)
               regs[ctrl_req.addr] <= ctrl_req.wdata;
            ctrl_wait <= 1'b1;                                 // always at least one cycle
            wait_left <= int'($unsigned($random(seed)) % 4);   // 1 to 4 in total
         end
         else if (ctrl_wait)
         begin
            if (wait_left == 0)
               ctrl_wait <= 1'b0;
            else
               wait_left <= wait_left - 1;
         end
      end
   end

   assign ctrl_readdata = regs[held.addr];   // valid once wait drops

endmodule

/* bench/tb_analog_reconfig.sv */
// one request at a time, expected values come from a bench shadow of the pma registers
`timescale 1ns/1ps

module tb_analog_reconfig
   import reconfig_bus_pkg::*, analog_map_pkg::*;
();

   localparam logic [10:0] PMA_BASE = 11'h100;
   localparam int          NUM_REQ  = 94;    // all requests issued below
   localparam int          PERIOD   = 100;

   // bench copies of the code tables
   localparam logic [3:0]  DC_REF [5] = '{4'b0000, 4'b1000, 4'b1100, 4'b1110, 4'b1111};
   localparam logic [14:0] EQ_REF [16] = '{
      15'b000_000_000_000_000, 15'b000_000_000_000_011, 15'b000_000_000_000_100,
      15'b100_000_000_000_111, 15'b111_000_000_000_111, 15'b000_000_000_111_111,
      15'b100_000_000_111_111, 15'b000_000_011_111_111, 15'b000_000_111_111_111,
      15'b010_000_111_111_111, 15'b100_000_111_111_111, 15'b000_111_111_111_111,
      15'b010_111_111_111_111, 15'b100_111_111_111_111, 15'b110_111_111_111_111,
      15'b111_111_111_111_111
   };

   logic        clk;
   logic        reset;
   logic        user_go;
   user_req_t   user_req;
   logic        user_busy, offset_error, channel_error;
   logic [31:0] user_readdata;
   logic        ctrl_go, ctrl_wait, ctrl_illegal_ch;
   ctrl_req_t   ctrl_req;
   logic [31:0] ctrl_readdata;
   logic        bad_channel, preload_en;
   logic [10:0] preload_addr;
   logic [31:0] preload_data;

   logic [31:0] shadow [2048];   // expected pma contents
   logic [3:0]  eq_idx;          // last equalizer index written
   int          seed;
   int          go_count;
   int          error_count;

   analog_reconfig_top #(.PMA_BASE(PMA_BASE)) DUT (
      .clk(clk), .reset(reset), .user_go(user_go), .user_req(user_req),
      .user_busy(user_busy), .offset_error(offset_error), .channel_error(channel_error),
      .user_readdata(user_readdata), .ctrl_go(ctrl_go), .ctrl_req(ctrl_req),
      .ctrl_wait(ctrl_wait), .ctrl_illegal_ch(ctrl_illegal_ch),
      .ctrl_readdata(ctrl_readdata)
   );

   pma_reg_model #(.SEED(32'h3ace178f)) u_model (
      .clk(clk), .reset(reset), .ctrl_go(ctrl_go), .ctrl_req(ctrl_req),
      .ctrl_wait(ctrl_wait), .ctrl_readdata(ctrl_readdata),
      .ctrl_illegal_ch(ctrl_illegal_ch), .bad_channel(bad_channel),
      .preload_en(preload_en), .preload_addr(preload_addr), .preload_data(preload_data)
   );

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD/2) clk = ~clk;
   end

   always @(posedge clk)
      if (ctrl_go)
         go_count <= go_count + 1;   // control ops seen

   // watchdog, worst case about 12 cycles per request
   initial
   begin
      #((NUM_REQ * 12 + 100) * PERIOD);
      $display("run timed out before all requests finished");
      $display("Checks failed");
      $fatal(1);
   end

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   function automatic logic [10:0] reg_index(input logic [5:0] offset);
      case (offset)
         OFS_VOD:       return 11'd5;
         OFS_POSTTAP1:  return 11'd3;
         OFS_RX_DCGAIN: return 11'd25;
         default:       return 11'd24;
      endcase
   endfunction

   // returns {new register word, user read data}
   function automatic logic [63:0] expect_result(input logic write, input logic [5:0] offset,
      input logic [31:0] wdata, input logic [31:0] old_word, input logic [3:0] eq_last);
      int          ofs;
      int          len;
      logic [31:0] lmask;
      logic [31:0] enc;
      logic [31:0] word;
      logic [31:0] fld;
      logic [31:0] rdata;
      case (offset)
         OFS_VOD:       begin ofs = 0; len = 6;  end
         OFS_POSTTAP1:  begin ofs = 3; len = 5;  end
         OFS_RX_DCGAIN: begin ofs = 0; len = 4;  end
         default:       begin ofs = 1; len = 15; end
      endcase
      lmask = (32'd1 << len) - 32'd1;
      if (offset == OFS_RX_DCGAIN)
         enc = (wdata > 4) ? 32'hf : {28'd0, DC_REF[wdata[2:0]]};   // saturate
      else if (offset == OFS_RX_EQCTRL)
         enc = {17'd0, EQ_REF[wdata[3:0]]};
      else
         enc = wdata;
      word  = write ? ((old_word & ~(lmask << ofs)) | ((enc & lmask) << ofs)) : old_word;
      fld   = (word >> ofs) & lmask;
      rdata = fld;
      if (offset == OFS_RX_DCGAIN)
      begin
         rdata = 0;   // unknown code
         for (int i = 0; i < 5; i++)
            if (fld[3:0] == DC_REF[i])
               rdata = i;
      end
      else if (offset == OFS_RX_EQCTRL)
         rdata = {28'd0, write ? wdata[3:0] : eq_last};
      return {word, rdata};
   endfunction

   task automatic compare(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
      if (expected !== actual)
      begin
         error_count++;
         $display("FAILED %s expected %h actual %h", name, expected, actual);
         $display("Checks failed");
         $fatal(1);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   task automatic run_request(input logic write, input logic [5:0] offset,
                              input logic [31:0] wdata, input string name);
      logic [10:0] addr;
      logic [63:0] exp;
      int          go_before;
      logic        legal;
      addr      = PMA_BASE + reg_index(offset);
      legal     = (offset == OFS_VOD) || (offset == OFS_POSTTAP1) ||
                  (offset == OFS_RX_DCGAIN) || (offset == OFS_RX_EQCTRL);
      exp       = expect_result(write, offset, wdata, shadow[addr], eq_idx);
      go_before = go_count;
      @(posedge clk);
      #5;
      user_req = '{write: write, offset: offset, wdata: wdata};
      user_go  = 1'b1;
      @(posedge clk);
      #5;
      user_go = 1'b0;
      compare({name, " busy"}, {31'd0, legal}, {31'd0, user_busy});   // high only for a legal go
      while (user_busy)
      begin
         @(posedge clk);
         #1;
      end
      compare({name, " offset_error"}, {31'd0, !legal}, {31'd0, offset_error});
      if (!legal)
         compare({name, " ctrl_go count"}, go_before, go_count);   // nothing issued
      else if (write)
      begin
         compare({name, " register"}, exp[63:32], u_model.regs[addr]);
         shadow[addr] = exp[63:32];
         if (offset == OFS_RX_EQCTRL)
            eq_idx = wdata[3:0];
      end
      else
         compare({name, " readdata"}, exp[31:0], user_readdata);
   endtask

   initial
   begin
      logic [5:0]  ofs;
      logic [31:0] val;
      seed         = 32'h3ace178f;
      go_count     = 0;
      error_count  = 0;
      eq_idx       = 4'd0;
      user_go      = 1'b0;
      user_req     = '0;
      bad_channel  = 1'b0;
      preload_en   = 1'b0;
      preload_addr = '0;
      preload_data = '0;
      reset        = 1'b1;
      for (int a = 0; a < 2048; a++)
         shadow[a] = {a[10:0], a[10:0], a[9:0]} ^ 32'h5a5a_c3c3;   // model fill
      repeat (2) @(posedge clk);
      #5 reset = 1'b0;

      // plain fields, random values
      for (int i = 0; i < 20; i++)
      begin
         ofs = ($random(seed) & 1) ? OFS_POSTTAP1 : OFS_VOD;
         val = $random(seed);
         run_request(1'b1, ofs, val, "plain write");
         run_request(1'b0, ofs, 32'd0, "plain read");
      end

      // dc gain incl. saturation
      for (int c = 0; c < 8; c++)
      begin
         run_request(1'b1, OFS_RX_DCGAIN, c, "dcgain write");
         run_request(1'b0, OFS_RX_DCGAIN, 32'd0, "dcgain read");
      end
      @(posedge clk);
      #5;
      preload_en   = 1'b1;   // 0101 is no thermometer code
      preload_addr = PMA_BASE + 11'd25;
      preload_data = 32'h0000_0005;
      @(posedge clk);
      #5 preload_en = 1'b0;
      shadow[PMA_BASE + 11'd25] = 32'h0000_0005;
      run_request(1'b0, OFS_RX_DCGAIN, 32'd0, "dcgain unknown read");

      // equalizer table, every index
      for (int e = 0; e < 16; e++)
      begin
         run_request(1'b1, OFS_RX_EQCTRL, e, "eqctrl write");
         run_request(1'b0, OFS_RX_EQCTRL, 32'd0, "eqctrl read");
      end

      // unlisted offsets then a legal one clears the flag
      run_request(1'b1, 6'd7, 32'h1234, "illegal write");
      run_request(1'b0, 6'd40, 32'd0, "illegal read");
      run_request(1'b0, OFS_VOD, 32'd0, "recover read");

      // illegal channel flag pass-through
      bad_channel = 1'b1;
      run_request(1'b0, OFS_POSTTAP1, 32'd0, "bad channel read");
      compare("channel_error set", 32'd1, {31'd0, channel_error});
      bad_channel = 1'b0;
      run_request(1'b0, OFS_POSTTAP1, 32'd0, "good channel read");
      compare("channel_error clear", 32'd0, {31'd0, channel_error});

      if (error_count == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

/* all.f */
design/reconfig_bus_pkg.sv
design/analog_map_pkg.sv
design/analog_field_decode.sv
design/rmw_sequencer.sv
design/field_readback.sv
design/analog_reconfig_top.sv
bench/pma_reg_model.sv
bench/tb_analog_reconfig.sv

/* run_sim.sh */
#!/bin/sh
# build and run with Verilator, result decided from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_analog_reconfig \
   -f all.f -o tb_sim > sim.log 2>&1 \
   && ./obj_dir/tb_sim >> sim.log 2>&1 \
   || echo "simulation ended with an error status" >> sim.log
cat sim.log
grep -q "Checks failed" sim.log && exit 1
grep -q "All checks passed" sim.log || exit 1
exit 0
